//--- verilog/spi_pkg.sv
package spi_pkg;

	// ======================================================================
	// sizes and register offsets
	// ======================================================================

	localparam int W_DATA = 8;
	localparam int FIFO_DEPTH = 2;
	localparam int W_FLEVEL = $clog2(FIFO_DEPTH + 1);
	localparam int W_FPTR = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int W_DIV = 6;

	localparam logic [15:0] ADDR_CSR = 16'h0000;
	localparam logic [15:0] ADDR_FSTAT = 16'h0004;
	localparam logic [15:0] ADDR_TX = 16'h0008;
	localparam logic [15:0] ADDR_RX = 16'h000c;

	// ======================================================================
	// shared types
	// ======================================================================

	// settings the register block hands to the engine.
	typedef struct packed {
		logic             csauto;
		logic             cs;
		logic             read_en;
		logic             cpol;
		logic             cpha;
		logic [W_DIV-1:0] div;
	} spi_cfg_t;

	typedef struct packed {
		logic [W_FLEVEL-1:0] level;
		logic                full;
		logic                empty;
	} fifo_stat_t;

	// control register at ADDR_CSR. The busy bit is read-only.
	typedef struct packed {
		logic [9:0] rsvd_31_22;
		logic [5:0] div;
		logic [6:0] rsvd_15_9;
		logic       busy;
		logic [1:0] rsvd_7_6;
		logic       cpha;
		logic       cpol;
		logic       rsvd_3;
		logic       read_en;
		logic       cs;
		logic       csauto;
	} csr_word_t;

	// FIFO status at ADDR_FSTAT. The over and under bits are sticky and clear on a write of 1.
	typedef struct packed {
		logic [3:0] rsvd_31_28;
		logic       rxunder;
		logic       rxover;
		logic       rxempty;
		logic       rxfull;
		logic [7:0] rxlevel;
		logic [4:0] rsvd_15_11;
		logic       txover;
		logic       txempty;
		logic       txfull;
		logic [7:0] txlevel;
	} fstat_word_t;

	typedef union packed {
		csr_word_t   csr;
		fstat_word_t fstat;
		logic [31:0] raw;
	} reg_word_u;

	// one data state per bit, MSB first.
	typedef enum logic [3:0] {
		S_IDLE      = 4'h0,
		S_DATA0     = 4'h1,
		S_DATA1     = 4'h2,
		S_DATA2     = 4'h3,
		S_DATA3     = 4'h4,
		S_DATA4     = 4'h5,
		S_DATA5     = 4'h6,
		S_DATA6     = 4'h7,
		S_DATA7     = 4'h8,
		S_BACKPORCH = 4'h9
	} spi_state_e;

endpackage

//--- verilog/sync_fifo.sv
module sync_fifo (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic [spi_pkg::W_DATA-1:0] wdata_i,
	input  logic                       wen_i,
	input  logic                       ren_i,
	output logic [spi_pkg::W_DATA-1:0] rdata_o,
	output spi_pkg::fifo_stat_t        stat_o
);
	import spi_pkg::*;

	logic [W_DATA-1:0]   mem [FIFO_DEPTH];
	logic [W_FPTR-1:0]   wptr;
	logic [W_FPTR-1:0]   rptr;
	logic [W_FLEVEL-1:0] level;
	logic                full;
	logic                empty;
	logic                do_wr;
	logic                do_rd;

	assign full = level == W_FLEVEL'(FIFO_DEPTH);
	assign empty = level == '0;

	// a write into a full FIFO or a read from an empty one has no effect.
	assign do_wr = wen_i && !full;
	assign do_rd = ren_i && !empty;

	always_ff @(posedge clk) begin
		if (do_wr)
			mem[wptr] <= wdata_i;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wptr <= '0;
			rptr <= '0;
			level <= '0;
		end else begin
			if (do_wr)
				wptr <= (wptr == W_FPTR'(FIFO_DEPTH - 1)) ? '0 : wptr + 1'b1;
			if (do_rd)
				rptr <= (rptr == W_FPTR'(FIFO_DEPTH - 1)) ? '0 : rptr + 1'b1;
			case ({do_wr, do_rd})
			2'b10: level <= level + 1'b1;
			2'b01: level <= level - 1'b1;
			default: level <= level;
			endcase
		end
	end

	// the head entry is always on the read port.
	assign rdata_o = mem[rptr];

	assign stat_o.level = level;
	assign stat_o.full = full;
	assign stat_o.empty = empty;

endmodule

//--- verilog/spi_engine.sv
module spi_engine (
	input  logic                       clk,
	input  logic                       rst_n,
	input  spi_pkg::spi_cfg_t          cfg_i,
	input  spi_pkg::fifo_stat_t        tx_stat_i,
	input  logic [spi_pkg::W_DATA-1:0] tx_data_i,
	input  logic                       sdi_i,
	output logic                       tx_pop_o,
	output logic                       rx_push_o,
	output logic [spi_pkg::W_DATA-1:0] rx_data_o,
	output logic                       busy_o,
	output logic                       cs_r_o,
	output logic                       sclk_r_o,
	output logic                       sdo_o
);
	import spi_pkg::*;

	logic [W_DIV-1:0]  div_ctr;
	logic              clk_en;
	spi_state_e        state;
	logic [W_DATA-1:0] tx_shift;
	logic [W_DATA-1:0] rx_shift;
	logic              last_edge;
	logic              load;

	// ======================================================================
	// clock enable divider
	// ======================================================================

	// the counter reloads from div when it reaches 1, so div 0 wraps
	// through the full 6-bit range and gives one enable per 64 cycles.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			clk_en <= 1'b0;
			div_ctr <= W_DIV'(1);
		end else if (div_ctr == W_DIV'(1)) begin
			clk_en <= 1'b1;
			div_ctr <= cfg_i.div;
		end else begin
			clk_en <= 1'b0;
			div_ctr <= div_ctr - 1'b1;
		end
	end

	// ======================================================================
	// shift state machine
	// ======================================================================

	// the trailing half of the last bit, where the next byte may be loaded.
	assign last_edge = (state == S_DATA7) && sclk_r_o;

	assign load = clk_en && !tx_stat_i.empty && (state == S_IDLE || last_edge);
	assign tx_pop_o = load;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= S_IDLE;
			cs_r_o <= 1'b1;
			sclk_r_o <= 1'b0;
			sdo_o <= 1'b0;
			rx_push_o <= 1'b0;
			tx_shift <= '0;
			rx_shift <= '0;
		end else begin
			rx_push_o <= 1'b0;
			if (clk_en) begin
				case (state)
				S_IDLE: begin
					if (load) begin
						state <= S_DATA0;
						cs_r_o <= 1'b0;
						tx_shift <= tx_data_i;
						// with cpha clear the MSB must be valid before the first edge.
						if (!cfg_i.cpha)
							sdo_o <= tx_data_i[W_DATA-1];
					end
				end
				S_BACKPORCH: begin
					state <= S_IDLE;
					cs_r_o <= 1'b1;
					sdo_o <= 1'b0;
				end
				default: begin
					sclk_r_o <= !sclk_r_o;
					// sample on the half where the clock phase matches cpha.
					if (cfg_i.cpha == sclk_r_o)
						rx_shift <= {rx_shift[W_DATA-2:0], sdi_i};
					if (state != S_DATA7) begin
						if (sclk_r_o) begin
							state <= spi_state_e'(state + 4'd1);
							tx_shift <= tx_shift << 1;
						end
						if (cfg_i.cpha != sclk_r_o)
							sdo_o <= cfg_i.cpha ? tx_shift[W_DATA-1] : tx_shift[W_DATA-2];
					end else begin
						if (cfg_i.cpha && !sclk_r_o)
							sdo_o <= tx_shift[W_DATA-1];
						if (sclk_r_o) begin
							// the byte is complete once this half ends.
							rx_push_o <= cfg_i.read_en;
							if (load) begin
								state <= S_DATA0;
								tx_shift <= tx_data_i;
								if (!cfg_i.cpha)
									sdo_o <= tx_data_i[W_DATA-1];
							end else begin
								state <= S_BACKPORCH;
							end
						end
					end
				end
				endcase
			end
		end
	end

	assign rx_data_o = rx_shift;
	assign busy_o = state != S_IDLE;

endmodule

//--- verilog/spi_regs.sv
module spi_regs (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       psel_i,
	input  logic                       penable_i,
	input  logic                       pwrite_i,
	input  logic [15:0]                paddr_i,
	input  logic [31:0]                pwdata_i,
	input  logic                       busy_i,
	input  spi_pkg::fifo_stat_t        tx_stat_i,
	input  spi_pkg::fifo_stat_t        rx_stat_i,
	input  logic [spi_pkg::W_DATA-1:0] rx_data_i,
	input  logic                       rx_push_i,
	output logic [31:0]                prdata_o,
	output logic                       pready_o,
	output logic                       pslverr_o,
	output spi_pkg::spi_cfg_t          cfg_o,
	output logic                       tx_push_o,
	output logic [spi_pkg::W_DATA-1:0] tx_data_o,
	output logic                       rx_pop_o
);
	import spi_pkg::*;

	logic      acc;
	logic      sel_csr;
	logic      sel_fstat;
	logic      sel_tx;
	logic      sel_rx;
	reg_word_u wr;
	reg_word_u rd;
	spi_cfg_t  cfg;
	logic      txover;
	logic      rxover;
	logic      rxunder;

	// ======================================================================
	// address decode
	// ======================================================================

	assign acc = psel_i && penable_i;
	assign sel_csr = paddr_i == ADDR_CSR;
	assign sel_fstat = paddr_i == ADDR_FSTAT;
	assign sel_tx = paddr_i == ADDR_TX;
	assign sel_rx = paddr_i == ADDR_RX;

	assign pready_o = 1'b1;
	// TX is write only.
	assign pslverr_o = acc && (!(sel_csr || sel_fstat || sel_tx || sel_rx) ||
		(sel_tx && !pwrite_i));

	assign wr = reg_word_u'(pwdata_i);

	assign tx_push_o = acc && pwrite_i && sel_tx;
	assign tx_data_o = pwdata_i[W_DATA-1:0];
	assign rx_pop_o = acc && !pwrite_i && sel_rx;

	// ======================================================================
	// control register and sticky flags
	// ======================================================================

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			// automatic chip select out of reset keeps cs_n high.
			cfg <= '{csauto: 1'b1, default: '0};
		end else if (acc && pwrite_i && sel_csr) begin
			cfg.csauto <= wr.csr.csauto;
			cfg.cs <= wr.csr.cs;
			cfg.read_en <= wr.csr.read_en;
			cfg.cpol <= wr.csr.cpol;
			cfg.cpha <= wr.csr.cpha;
			cfg.div <= wr.csr.div;
		end
	end

	assign cfg_o = cfg;

	// a new event in the same cycle as a clear leaves the flag set.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			txover <= 1'b0;
			rxover <= 1'b0;
			rxunder <= 1'b0;
		end else begin
			if (acc && pwrite_i && sel_fstat) begin
				if (wr.fstat.txover)
					txover <= 1'b0;
				if (wr.fstat.rxover)
					rxover <= 1'b0;
				if (wr.fstat.rxunder)
					rxunder <= 1'b0;
			end
			if (tx_push_o && tx_stat_i.full)
				txover <= 1'b1;
			if (rx_push_i && rx_stat_i.full)
				rxover <= 1'b1;
			if (rx_pop_o && rx_stat_i.empty)
				rxunder <= 1'b1;
		end
	end

	// ======================================================================
	// read data
	// ======================================================================

	always_comb begin
		rd.raw = '0;
		if (sel_csr) begin
			rd.csr.csauto = cfg.csauto;
			rd.csr.cs = cfg.cs;
			rd.csr.read_en = cfg.read_en;
			rd.csr.cpol = cfg.cpol;
			rd.csr.cpha = cfg.cpha;
			rd.csr.busy = busy_i;
			rd.csr.div = cfg.div;
		end else if (sel_fstat) begin
			rd.fstat.txlevel = 8'(tx_stat_i.level);
			rd.fstat.txfull = tx_stat_i.full;
			rd.fstat.txempty = tx_stat_i.empty;
			rd.fstat.txover = txover;
			rd.fstat.rxlevel = 8'(rx_stat_i.level);
			rd.fstat.rxfull = rx_stat_i.full;
			rd.fstat.rxempty = rx_stat_i.empty;
			rd.fstat.rxover = rxover;
			rd.fstat.rxunder = rxunder;
		end else if (sel_rx) begin
			rd.raw[W_DATA-1:0] = rx_data_i;
		end
	end

	assign prdata_o = rd.raw;

endmodule

//--- verilog/spi_mini.sv
module spi_mini (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        psel_i,
	input  logic        penable_i,
	input  logic        pwrite_i,
	input  logic [15:0] paddr_i,
	input  logic [31:0] pwdata_i,
	output logic [31:0] prdata_o,
	output logic        pready_o,
	output logic        pslverr_o,
	output logic        sclk_o,
	output logic        sdo_o,
	input  logic        sdi_i,
	output logic        cs_n_o
);
	import spi_pkg::*;

	spi_cfg_t          cfg;
	fifo_stat_t        tx_stat;
	fifo_stat_t        rx_stat;
	logic              busy;
	logic              tx_push;
	logic [W_DATA-1:0] tx_wdata;
	logic [W_DATA-1:0] tx_head;
	logic              tx_pop;
	logic              rx_push;
	logic [W_DATA-1:0] rx_wdata;
	logic [W_DATA-1:0] rx_head;
	logic              rx_pop;
	logic              cs_r;
	logic              sclk_r;

	spi_regs u_regs (
		.clk       (clk),
		.rst_n     (rst_n),
		.psel_i    (psel_i),
		.penable_i (penable_i),
		.pwrite_i  (pwrite_i),
		.paddr_i   (paddr_i),
		.pwdata_i  (pwdata_i),
		.busy_i    (busy),
		.tx_stat_i (tx_stat),
		.rx_stat_i (rx_stat),
		.rx_data_i (rx_head),
		.rx_push_i (rx_push),
		.prdata_o  (prdata_o),
		.pready_o  (pready_o),
		.pslverr_o (pslverr_o),
		.cfg_o     (cfg),
		.tx_push_o (tx_push),
		.tx_data_o (tx_wdata),
		.rx_pop_o  (rx_pop)
	);

	sync_fifo u_txfifo (
		.clk     (clk),
		.rst_n   (rst_n),
		.wdata_i (tx_wdata),
		.wen_i   (tx_push),
		.ren_i   (tx_pop),
		.rdata_o (tx_head),
		.stat_o  (tx_stat)
	);

	sync_fifo u_rxfifo (
		.clk     (clk),
		.rst_n   (rst_n),
		.wdata_i (rx_wdata),
		.wen_i   (rx_push),
		.ren_i   (rx_pop),
		.rdata_o (rx_head),
		.stat_o  (rx_stat)
	);

	spi_engine u_engine (
		.clk       (clk),
		.rst_n     (rst_n),
		.cfg_i     (cfg),
		.tx_stat_i (tx_stat),
		.tx_data_i (tx_head),
		.sdi_i     (sdi_i),
		.tx_pop_o  (tx_pop),
		.rx_push_o (rx_push),
		.rx_data_o (rx_wdata),
		.busy_o    (busy),
		.cs_r_o    (cs_r),
		.sclk_r_o  (sclk_r),
		.sdo_o     (sdo_o)
	);

	// in manual mode software drives chip select straight from the CSR.
	assign cs_n_o = cfg.csauto ? cs_r : cfg.cs;
	assign sclk_o = sclk_r ^ cfg.cpol;

endmodule

//--- dv/spi_mini_chk.sv
module spi_mini_chk (
	input logic                clk,
	input logic                rst_n,
	input spi_pkg::spi_state_e state_i,
	input logic                sclk_r_i,
	input logic                cs_r_i,
	input logic                rx_push_i,
	input logic                read_en_i
);
	timeunit 1ns;
	timeprecision 100ps;
	import spi_pkg::*;

	// the raw clock phase rests at 0 whenever no frame is running.
	sclk_low_in_idle: assert property (@(posedge clk) disable iff (!rst_n)
		(state_i == S_IDLE) |-> !sclk_r_i)
		else $error("engine clock phase is high in idle");

	// a received byte only goes to the RX FIFO while reading is enabled.
	push_needs_read_en: assert property (@(posedge clk) disable iff (!rst_n)
		rx_push_i |-> read_en_i)
		else $error("receive push while read_en is clear");

	cs_tracks_idle: assert property (@(posedge clk) disable iff (!rst_n)
		cs_r_i == (state_i == S_IDLE))
		else $error("engine chip select does not match the idle state");

endmodule

bind spi_engine spi_mini_chk u_chk (
	.clk       (clk),
	.rst_n     (rst_n),
	.state_i   (state),
	.sclk_r_i  (sclk_r_o),
	.cs_r_i    (cs_r_o),
	.rx_push_i (rx_push_o),
	.read_en_i (cfg_i.read_en)
);

//--- dv/tb_spi_mini.sv
module tb_spi_mini;
	timeunit 1ns;
	timeprecision 100ps;
	import spi_pkg::*;

	localparam int N_ROWS = 8;
	localparam int CYCLE_LIMIT = 20 * N_ROWS * FIFO_DEPTH * 16 * 65;

	// one loopback test. data[0] is sent first.
	typedef struct packed {
		logic                              cpol;
		logic                              cpha;
		logic [W_DIV-1:0]                  div;
		logic                              read_en;
		logic [1:0]                        nbytes;
		logic                              rand_bytes;
		logic [FIFO_DEPTH-1:0][W_DATA-1:0] data;
	} row_t;

	logic        clk = 1'b0;
	logic        rst_n;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [15:0] paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic        pready;
	logic        pslverr;
	logic        sclk;
	logic        sdo;
	logic        sdi = 1'b0;
	logic        cs_n;
	int          cycles = 0;
	logic [31:0] lcg_state = 32'h93f0_d136;

	// cpol, cpha, div, read_en, nbytes, rand_bytes, {data[1], data[0]}.
	row_t rows [N_ROWS] = '{
		'{1'b0, 1'b0, 6'd1, 1'b1, 2'd2, 1'b0, {8'h3c, 8'ha5}},
		'{1'b0, 1'b1, 6'd3, 1'b1, 2'd2, 1'b0, {8'h01, 8'h80}},
		'{1'b1, 1'b0, 6'd17, 1'b1, 2'd2, 1'b1, 16'h0000},
		'{1'b1, 1'b1, 6'd1, 1'b1, 2'd2, 1'b1, 16'h0000},
		'{1'b0, 1'b0, 6'd17, 1'b1, 2'd1, 1'b0, {8'h00, 8'hff}},
		'{1'b1, 1'b1, 6'd3, 1'b1, 2'd2, 1'b1, 16'h0000},
		'{1'b1, 1'b0, 6'd3, 1'b1, 2'd2, 1'b1, 16'h0000},
		'{1'b0, 1'b1, 6'd1, 1'b0, 2'd2, 1'b0, {8'h96, 8'h69}}
	};

	spi_mini u_dut (
		.clk       (clk),
		.rst_n     (rst_n),
		.psel_i    (psel),
		.penable_i (penable),
		.pwrite_i  (pwrite),
		.paddr_i   (paddr),
		.pwdata_i  (pwdata),
		.prdata_o  (prdata),
		.pready_o  (pready),
		.pslverr_o (pslverr),
		.sclk_o    (sclk),
		.sdo_o     (sdo),
		.sdi_i     (sdi),
		.cs_n_o    (cs_n)
	);

	always #4 clk = ~clk;

	// sdo is looped back to sdi on the falling edge.
	always @(negedge clk) sdi <= sdo;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: transfers did not finish");
			stop_failed();
		end
	end

	// ======================================================================
	// helpers
	// ======================================================================

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic [W_DATA-1:0] rand_byte();
		lcg_state = lcg_next(lcg_state);
		return lcg_state[31:24];
	endfunction

	function automatic csr_word_t make_csr(input logic csauto, input logic cs,
		input logic read_en, input logic cpol, input logic cpha, input logic [W_DIV-1:0] div);
		csr_word_t c;
		c = '0;
		c.csauto = csauto;
		c.cs = cs;
		c.read_en = read_en;
		c.cpol = cpol;
		c.cpha = cpha;
		c.div = div;
		return c;
	endfunction

	// both FIFOs empty, no sticky flag.
	function automatic fstat_word_t idle_stat();
		fstat_word_t s;
		s = '0;
		s.txempty = 1'b1;
		s.rxempty = 1'b1;
		return s;
	endfunction

	task automatic stop_failed();
		$display("TEST FAILED");
		$fatal(1, "stopped at the first failure");
	endtask

	task automatic check_bit(input string what, input logic exp, input logic act);
		if (act !== exp) begin
			$display("error at %0t: %s expected %b got %b", $time, what, exp, act);
			stop_failed();
		end
	endtask

	task automatic check_byte(input string what, input logic [W_DATA-1:0] exp,
		input logic [W_DATA-1:0] act);
		if (act !== exp) begin
			$display("error at %0t: %s expected %02h got %02h", $time, what, exp, act);
			stop_failed();
		end
	endtask

	task automatic check_stat(input string what, input fstat_word_t exp, input fstat_word_t act);
		if (act !== exp) begin
			$display("error at %0t: %s expected %08h got %08h", $time, what, exp, act);
			stop_failed();
		end
	endtask

	task automatic check_csr(input string what, input csr_word_t exp, input csr_word_t act);
		if (act !== exp) begin
			$display("error at %0t: %s expected %08h got %08h", $time, what, exp, act);
			stop_failed();
		end
	endtask

	// ======================================================================
	// APB access
	// ======================================================================

	// outputs are sampled early in the low half of the access cycle, where they are settled.
	task automatic apb_write(input logic [15:0] addr, input logic [31:0] data,
		input logic exp_err);
		@(negedge clk);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b1;
		paddr = addr;
		pwdata = data;
		@(negedge clk);
		penable = 1'b1;
		#1;
		check_bit("pready_o", 1'b1, pready);
		check_bit($sformatf("pslverr_o on write to %04h", addr), exp_err, pslverr);
		@(negedge clk);
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic apb_read(input logic [15:0] addr, input logic exp_err,
		output logic [31:0] data);
		@(negedge clk);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = addr;
		@(negedge clk);
		penable = 1'b1;
		#1;
		check_bit("pready_o", 1'b1, pready);
		check_bit($sformatf("pslverr_o on read of %04h", addr), exp_err, pslverr);
		data = prdata;
		@(negedge clk);
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic wait_tx_loaded();
		reg_word_u w;
		w.raw = '0;
		while (!w.fstat.txempty)
			apb_read(ADDR_FSTAT, 1'b0, w.raw);
	endtask

	// once the TX FIFO is empty, busy can only fall, so both reads together mark the end.
	task automatic wait_idle();
		reg_word_u w;
		logic done;
		done = 1'b0;
		while (!done) begin
			apb_read(ADDR_FSTAT, 1'b0, w.raw);
			if (w.fstat.txempty) begin
				apb_read(ADDR_CSR, 1'b0, w.raw);
				done = !w.csr.busy;
			end
		end
	endtask

	// ======================================================================
	// tests
	// ======================================================================

	task automatic reset_test();
		reg_word_u w;
		check_bit("cs_n_o after reset", 1'b1, cs_n);
		check_bit("sclk_o after reset", 1'b0, sclk);
		check_bit("sdo_o after reset", 1'b0, sdo);
		apb_read(ADDR_CSR, 1'b0, w.raw);
		check_bit("busy after reset", 1'b0, w.csr.busy);
		apb_read(ADDR_FSTAT, 1'b0, w.raw);
		check_stat("status after reset", idle_stat(), w.fstat);
	endtask

	task automatic run_row(input int idx, input row_t r);
		reg_word_u w;
		w.raw = '0;
		w.csr = make_csr(1'b1, 1'b0, r.read_en, r.cpol, r.cpha, r.div);
		apb_write(ADDR_CSR, w.raw, 1'b0);
		for (int i = 0; i < int'(r.nbytes); i++)
			apb_write(ADDR_TX, 32'(r.data[i]), 1'b0);
		wait_idle();
		check_bit($sformatf("row %0d sclk_o in idle", idx), r.cpol, sclk);
		check_bit($sformatf("row %0d cs_n_o in idle", idx), 1'b1, cs_n);
		if (r.read_en) begin
			for (int i = 0; i < int'(r.nbytes); i++) begin
				apb_read(ADDR_RX, 1'b0, w.raw);
				check_byte($sformatf("row %0d byte %0d", idx, i), r.data[i], w.raw[W_DATA-1:0]);
			end
		end
		// the RX FIFO ends empty, whether its bytes were read back or never pushed.
		apb_read(ADDR_FSTAT, 1'b0, w.raw);
		check_stat($sformatf("row %0d status", idx), idle_stat(), w.fstat);
	endtask

	task automatic rx_overflow_test();
		reg_word_u w;
		fstat_word_t exp;
		logic [W_DATA-1:0] sent [FIFO_DEPTH+1];
		w.raw = '0;
		w.csr = make_csr(1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 6'd1);
		apb_write(ADDR_CSR, w.raw, 1'b0);
		for (int i = 0; i <= FIFO_DEPTH; i++) begin
			sent[i] = rand_byte();
			apb_write(ADDR_TX, 32'(sent[i]), 1'b0);
			wait_tx_loaded();
		end
		wait_idle();
		exp = idle_stat();
		exp.rxlevel = 8'(FIFO_DEPTH);
		exp.rxfull = 1'b1;
		exp.rxempty = 1'b0;
		exp.rxover = 1'b1;
		apb_read(ADDR_FSTAT, 1'b0, w.raw);
		check_stat("status after RX overflow", exp, w.fstat);
		for (int i = 0; i < FIFO_DEPTH; i++) begin
			apb_read(ADDR_RX, 1'b0, w.raw);
			check_byte($sformatf("kept RX byte %0d", i), sent[i], w.raw[W_DATA-1:0]);
		end
		apb_read(ADDR_RX, 1'b0, w.raw);
		exp = idle_stat();
		exp.rxover = 1'b1;
		exp.rxunder = 1'b1;
		apb_read(ADDR_FSTAT, 1'b0, w.raw);
		check_stat("status after RX underflow", exp, w.fstat);
		w.raw = '0;
		w.fstat.rxover = 1'b1;
		w.fstat.rxunder = 1'b1;
		apb_write(ADDR_FSTAT, w.raw, 1'b0);
		apb_read(ADDR_FSTAT, 1'b0, w.raw);
		check_stat("status after RX flag clear", idle_stat(), w.fstat);
	endtask

	task automatic tx_overflow_test();
		reg_word_u w;
		fstat_word_t exp;
		w.raw = '0;
		w.csr = make_csr(1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 6'd63);
		apb_write(ADDR_CSR, w.raw, 1'b0);
		// at most one byte leaves the FIFO during these writes.
		for (int i = 0; i < FIFO_DEPTH + 2; i++)
			apb_write(ADDR_TX, 32'(rand_byte()), 1'b0);
		wait_idle();
		exp = idle_stat();
		exp.txover = 1'b1;
		apb_read(ADDR_FSTAT, 1'b0, w.raw);
		check_stat("status after TX overflow", exp, w.fstat);
		w.raw = '0;
		w.fstat.txover = 1'b1;
		apb_write(ADDR_FSTAT, w.raw, 1'b0);
		apb_read(ADDR_FSTAT, 1'b0, w.raw);
		check_stat("status after TX flag clear", idle_stat(), w.fstat);
	endtask

	task automatic reg_access_test();
		reg_word_u w;
		w.raw = '0;
		w.csr = make_csr(1'b0, 1'b1, 1'b1, 1'b1, 1'b0, 6'h2a);
		apb_write(ADDR_CSR, w.raw, 1'b0);
		check_bit("manual cs_n_o high", 1'b1, cs_n);
		check_bit("sclk_o with cpol set", 1'b1, sclk);
		apb_read(ADDR_CSR, 1'b0, w.raw);
		check_csr("CSR readback", make_csr(1'b0, 1'b1, 1'b1, 1'b1, 1'b0, 6'h2a), w.csr);
		w.csr = make_csr(1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 6'h05);
		apb_write(ADDR_CSR, w.raw, 1'b0);
		check_bit("manual cs_n_o low", 1'b0, cs_n);
		check_bit("sclk_o with cpol clear", 1'b0, sclk);
		apb_write(16'h0010, 32'hffff_ffff, 1'b1);
		apb_read(16'h0010, 1'b1, w.raw);
		apb_read(ADDR_TX, 1'b1, w.raw);
		apb_read(ADDR_FSTAT, 1'b0, w.raw);
		check_stat("status after bad accesses", idle_stat(), w.fstat);
	endtask

	initial begin
		rst_n = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		repeat (4) @(negedge clk);
		rst_n = 1'b1;
		reset_test();
		for (int r = 0; r < N_ROWS; r++) begin
			if (rows[r].rand_bytes) begin
				for (int i = 0; i < FIFO_DEPTH; i++)
					rows[r].data[i] = rand_byte();
			end
		end
		for (int r = 0; r < N_ROWS; r++)
			run_row(r, rows[r]);
		rx_overflow_test();
		tx_overflow_test();
		reg_access_test();
		$display("TEST PASSED");
		$finish;
	end

endmodule

//--- tb.f
verilog/spi_pkg.sv
verilog/sync_fifo.sv
verilog/spi_engine.sv
verilog/spi_regs.sv
verilog/spi_mini.sv
dv/spi_mini_chk.sv
dv/tb_spi_mini.sv

//--- run.sh
#!/bin/sh
# Build the SPI master testbench with Verilator and run it.
# The exit status of the simulation is the verdict.
set -e

cd "$(dirname "$0")"

verilator --binary --assert -j 0 --top-module tb_spi_mini -f tb.f

./obj_dir/Vtb_spi_mini
